//--- rtl/cache_back_end.sv
/*
 Cache back end
 Write-through FIFO, command credits and line fetch toward the next-level memory
 */

`timescale 1ns/1ps

module cache_back_end (
   input  logic                  clk,
   input  logic                  rst_n,
   // cache memory side
   input  logic                  write_valid,
   input  cache_pkg::word_addr_t write_addr,
   input  cache_pkg::data_t      write_wdata,
   input  cache_pkg::strb_t      write_wstrb,
   output logic                  write_ready,
   input  logic                  fetch_valid,
   input  cache_pkg::line_addr_t fetch_addr,
   output logic                  fetch_ready,
   output logic                  fill_valid,
   output cache_pkg::data_t      fill_word,
   output logic [cache_pkg::line_off_w-1:0] fill_off,
   // buffer-empty chain
   input  logic                  wtb_empty_in,
   output logic                  wtb_empty,
   output logic                  wtb_empty_out,
   // memory side
   output logic                  mem_cmd_valid,
   output cache_pkg::mem_cmd_e   mem_cmd,
   output cache_pkg::word_addr_t mem_addr,
   output cache_pkg::data_t      mem_wdata,
   output cache_pkg::strb_t      mem_wstrb,
   input  logic                  credit_return,
   input  logic                  mem_rsp_valid,
   input  cache_pkg::data_t      mem_rsp_data
);

   typedef logic [$clog2(cache_pkg::wtb_depth)-1:0]     ptr_t;
   typedef logic [$clog2(cache_pkg::wtb_depth+1)-1:0]   count_t;
   typedef logic [$clog2(cache_pkg::cmd_credits+1)-1:0] credit_t;

   cache_pkg::word_addr_t fifo_addr [cache_pkg::wtb_depth];
   cache_pkg::data_t      fifo_data [cache_pkg::wtb_depth];
   cache_pkg::strb_t      fifo_strb [cache_pkg::wtb_depth];
   ptr_t                  wr_ptr_q;
   ptr_t                  rd_ptr_q;
   count_t                count_q;
   credit_t               credit_q;
   logic                  fetch_pend_q;
   cache_pkg::line_addr_t line_q;
   logic                  push;
   logic                  pop;
   logic                  has_write;

   assign has_write     = (count_q != '0);
   assign wtb_empty     = !has_write;
   assign wtb_empty_out = wtb_empty && wtb_empty_in;

   assign write_ready = (count_q != count_t'(cache_pkg::wtb_depth));
   assign push        = write_valid && write_ready;
   // a fetch waits for the buffer to drain so reads never pass writes
   assign fetch_ready = fetch_valid && wtb_empty && !fetch_pend_q;

   // buffered writes go out before a pending line fetch
   assign mem_cmd_valid = (credit_q != '0) && (has_write || fetch_pend_q);
   assign pop           = mem_cmd_valid && has_write;
   assign mem_cmd       = has_write ? cache_pkg::write_word : cache_pkg::read_line;
   assign mem_addr      = has_write ? fifo_addr[rd_ptr_q] : {line_q, 2'b00};
   assign mem_wdata     = fifo_data[rd_ptr_q];
   assign mem_wstrb     = has_write ? fifo_strb[rd_ptr_q] : '0;

   assign fill_valid = mem_rsp_valid;
   assign fill_word  = mem_rsp_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         count_q      <= '0;
         credit_q     <= credit_t'(cache_pkg::cmd_credits);
         fetch_pend_q <= 1'b0;
         fill_off     <= '0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         case ({mem_cmd_valid, credit_return})
            2'b10:   credit_q <= credit_q - 1'b1;
            2'b01:   credit_q <= credit_q + 1'b1;
            default: credit_q <= credit_q;
         endcase
         if (fetch_ready) begin
            fetch_pend_q <= 1'b1;
         end else if (mem_cmd_valid && !has_write) begin
            fetch_pend_q <= 1'b0;
         end
         // beats arrive in word order
         if (mem_rsp_valid) fill_off <= fill_off + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_addr[wr_ptr_q] <= write_addr;
         fifo_data[wr_ptr_q] <= write_wdata;
         fifo_strb[wr_ptr_q] <= write_wstrb;
      end
      if (fetch_ready) line_q <= fetch_addr;
   end

   // memory must not hand back more credits than it granted
   a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      credit_q <= credit_t'(cache_pkg::cmd_credits));

endmodule

//--- rtl/cache_control.sv
/*
 Cache control block
 Hit and miss counters, status register and invalidate command
 */

`timescale 1ns/1ps

module cache_control (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ctrl_req,
   input  cache_pkg::ctrl_addr_t ctrl_addr,
   input  logic                  ctrl_write,
   output logic                  ctrl_ack,
   output cache_pkg::data_t      ctrl_rdata,
   // events from the cache memory
   input  logic                  read_hit,
   input  logic                  read_miss,
   input  logic                  write_hit,
   input  logic                  write_miss,
   input  logic                  wtb_empty,
   // invalidate chain
   input  logic                  invalidate_in,
   output logic                  invalidate_out
);

   cache_pkg::cnt_t     rd_hit_q;
   cache_pkg::cnt_t     rd_miss_q;
   cache_pkg::cnt_t     wr_hit_q;
   cache_pkg::cnt_t     wr_miss_q;
   cache_pkg::ctrl_reg_e reg_sel;
   logic                inv_q;
   logic                clear;

   assign reg_sel        = cache_pkg::ctrl_reg_e'(ctrl_addr);
   assign clear          = ctrl_req && ctrl_write && (reg_sel == cache_pkg::clear_counters);
   assign invalidate_out = inv_q || invalidate_in;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_ack  <= 1'b0;
         inv_q     <= 1'b0;
         rd_hit_q  <= '0;
         rd_miss_q <= '0;
         wr_hit_q  <= '0;
         wr_miss_q <= '0;
      end else begin
         ctrl_ack <= ctrl_req;
         inv_q    <= ctrl_req && ctrl_write && (reg_sel == cache_pkg::invalidate);
         if (clear) begin
            rd_hit_q  <= '0;
            rd_miss_q <= '0;
            wr_hit_q  <= '0;
            wr_miss_q <= '0;
         end else begin
            rd_hit_q  <= rd_hit_q + cache_pkg::cnt_t'(read_hit);
            rd_miss_q <= rd_miss_q + cache_pkg::cnt_t'(read_miss);
            wr_hit_q  <= wr_hit_q + cache_pkg::cnt_t'(write_hit);
            wr_miss_q <= wr_miss_q + cache_pkg::cnt_t'(write_miss);
         end
      end
   end

   // read mux, registered for the one cycle ack
   always_ff @(posedge clk) begin
      if (ctrl_req) begin
         case (reg_sel)
            cache_pkg::read_hits:    ctrl_rdata <= rd_hit_q;
            cache_pkg::read_misses:  ctrl_rdata <= rd_miss_q;
            cache_pkg::write_hits:   ctrl_rdata <= wr_hit_q;
            cache_pkg::write_misses: ctrl_rdata <= wr_miss_q;
            cache_pkg::status:       ctrl_rdata <= {31'b0, wtb_empty};
            default:                 ctrl_rdata <= '0;
         endcase
      end
   end

endmodule

//--- rtl/cache_front_end.sv
/*
 Cache front end
 Registers a CPU request and routes it to the cache memory or the control block
 */

`timescale 1ns/1ps

module cache_front_end (
   input  logic                  clk,
   input  logic                  rst_n,
   // cpu side
   input  logic                  req,
   input  logic                  ctrl_sel,
   input  cache_pkg::word_addr_t addr,
   input  cache_pkg::data_t      wdata,
   input  cache_pkg::strb_t      wstrb,
   output logic                  ack,
   output cache_pkg::data_t      rdata,
   // internal targets
   output logic                  data_req,
   output logic                  ctrl_req,
   output cache_pkg::word_addr_t addr_reg,
   output cache_pkg::data_t      wdata_reg,
   output cache_pkg::strb_t      wstrb_reg,
   input  logic                  data_ack,
   input  cache_pkg::data_t      data_rdata,
   input  logic                  ctrl_ack,
   input  cache_pkg::data_t      ctrl_rdata
);

   logic busy_q;
   logic accept;

   // req is still high during the ack cycle, so skip it there
   assign accept = req && !busy_q && !ack;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q   <= 1'b0;
         data_req <= 1'b0;
         ctrl_req <= 1'b0;
         ack      <= 1'b0;
      end else begin
         data_req <= accept && !ctrl_sel;
         ctrl_req <= accept && ctrl_sel;
         ack      <= busy_q && (data_ack || ctrl_ack);
         if (accept) begin
            busy_q <= 1'b1;
         end else if (data_ack || ctrl_ack) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_reg  <= addr;
         wdata_reg <= wdata;
         wstrb_reg <= wstrb;
      end
      if (ctrl_ack) begin
         rdata <= ctrl_rdata;
      end else if (data_ack) begin
         rdata <= data_rdata;
      end
   end

   // only one target may answer a request
   a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
      !(data_ack && ctrl_ack));

endmodule

//--- rtl/cache_memory.sv
/*
 Cache memory
 Tag, valid and data arrays of the direct-mapped cache, hit detection,
 line refill on a read miss and byte merge on a write hit
 */

`timescale 1ns/1ps

module cache_memory (
   input  logic                  clk,
   input  logic                  rst_n,
   // front end
   input  logic                  data_req,
   input  cache_pkg::word_addr_t addr_reg,
   input  cache_pkg::data_t      wdata_reg,
   input  cache_pkg::strb_t      wstrb_reg,
   output logic                  data_ack,
   output cache_pkg::data_t      data_rdata,
   // write channel
   output logic                  write_valid,
   output cache_pkg::word_addr_t write_addr,
   output cache_pkg::data_t      write_wdata,
   output cache_pkg::strb_t      write_wstrb,
   input  logic                  write_ready,
   // line fetch
   output logic                  fetch_valid,
   output cache_pkg::line_addr_t fetch_addr,
   input  logic                  fetch_ready,
   input  logic                  fill_valid,
   input  cache_pkg::data_t      fill_word,
   input  logic [cache_pkg::line_off_w-1:0] fill_off,
   // control
   input  logic                  invalidate_out,
   output logic                  read_hit,
   output logic                  read_miss,
   output logic                  write_hit,
   output logic                  write_miss
);

   localparam int nlines = 2 ** cache_pkg::index_w;
   localparam int nwords = 2 ** (cache_pkg::index_w + cache_pkg::line_off_w);

   cache_pkg::tag_t          tag_q [nlines];
   logic [nlines-1:0]        valid_q;
   cache_pkg::data_t         line_mem [nwords];

   cache_pkg::refill_state_e state_q;
   cache_pkg::data_t         rd_q;
   logic                     rd_ack_q;
   logic                     write_valid_q;

   cache_pkg::tag_t          tag;
   cache_pkg::index_t        idx;
   logic [cache_pkg::line_off_w-1:0] off;
   logic                     is_write;
   logic                     hit;
   logic                     fill_last;

   assign {tag, idx, off} = addr_reg;
   assign is_write  = |wstrb_reg;
   assign hit       = valid_q[idx] && (tag_q[idx] == tag);
   assign fill_last = fill_valid && (&fill_off);

   // one pulse per access, taken while data_req is high
   assign read_hit   = data_req && !is_write && hit;
   assign read_miss  = data_req && !is_write && !hit;
   assign write_hit  = data_req && is_write && hit;
   assign write_miss = data_req && is_write && !hit;

   // every write goes through to the back end
   assign write_valid = write_valid_q;
   assign write_addr  = addr_reg;
   assign write_wdata = wdata_reg;
   assign write_wstrb = wstrb_reg;

   assign fetch_valid = (state_q == cache_pkg::fetch);
   assign fetch_addr  = {tag, idx};

   assign data_ack   = rd_ack_q || (write_valid_q && write_ready);
   assign data_rdata = rd_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q       <= cache_pkg::idle;
         rd_ack_q      <= 1'b0;
         write_valid_q <= 1'b0;
         valid_q       <= '0;
      end else begin
         rd_ack_q <= read_hit || fill_last;
         if (data_req && is_write) begin
            write_valid_q <= 1'b1;
         end else if (write_ready) begin
            write_valid_q <= 1'b0;
         end
         case (state_q)
            cache_pkg::idle: begin
               if (read_miss) state_q <= cache_pkg::fetch;
            end
            cache_pkg::fetch: begin
               if (fetch_ready) state_q <= cache_pkg::fill;
            end
            default: begin
               if (fill_last) begin
                  state_q      <= cache_pkg::idle;
                  valid_q[idx] <= 1'b1;
               end
            end
         endcase
         // invalidate wins over a line completing in the same cycle
         if (invalidate_out) valid_q <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_valid) begin
         line_mem[{idx, fill_off}] <= fill_word;
      end else if (write_hit) begin
         for (int b = 0; b < cache_pkg::nbytes; b++) begin
            if (wstrb_reg[b]) line_mem[{idx, off}][8*b +: 8] <= wdata_reg[8*b +: 8];
         end
      end
      if (fill_last) tag_q[idx] <= tag;
      // requested word is caught as it streams in
      if (data_req) begin
         rd_q <= line_mem[{idx, off}];
      end else if (fill_valid && (fill_off == off)) begin
         rd_q <= fill_word;
      end
   end

   // refill beats from the back end only after a fetch was accepted
   a_fill_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
      fill_valid |-> state_q == cache_pkg::fill);

endmodule

//--- rtl/cache_pkg.sv
/*
 Direct-mapped write-through data cache
 Shared geometry, vector types and enums for all cache blocks
 */

package cache_pkg;

   // cpu side geometry, word addressed
   localparam int addr_w      = 12;
   localparam int data_w      = 32;
   localparam int nbytes      = 4;

   // address split is tag | index | word offset
   localparam int line_off_w  = 2;
   localparam int index_w     = 4;
   localparam int tag_w       = addr_w - index_w - line_off_w;
   localparam int line_addr_w = tag_w + index_w;

   // back end sizing
   localparam int wtb_depth   = 4;
   localparam int cmd_credits = 2;

   localparam int ctrl_addr_w = 3;

   typedef logic [addr_w-1:0]      word_addr_t;
   typedef logic [data_w-1:0]      data_t;
   typedef logic [nbytes-1:0]      strb_t;
   typedef logic [tag_w-1:0]       tag_t;
   typedef logic [index_w-1:0]     index_t;
   typedef logic [line_addr_w-1:0] line_addr_t;
   typedef logic [ctrl_addr_w-1:0] ctrl_addr_t;
   typedef logic [31:0]            cnt_t;

   // control block register map
   typedef enum logic [ctrl_addr_w-1:0] {
      read_hits      = 3'd0,
      read_misses    = 3'd1,
      write_hits     = 3'd2,
      write_misses   = 3'd3,
      status         = 3'd4,
      invalidate     = 3'd5,
      clear_counters = 3'd6
   } ctrl_reg_e;

   typedef enum logic [1:0] {
      idle,
      fetch,
      fill
   } refill_state_e;

   typedef enum logic {
      read_line  = 1'b0,
      write_word = 1'b1
   } mem_cmd_e;

endpackage

//--- rtl/cache_top.sv
/*
 Write-through data cache subsystem
 Front end, cache memory, back end and control block with the
 invalidate and buffer-empty chain for cascading caches
 */

`timescale 1ns/1ps

module cache_top (
   input  logic                  clk,
   input  logic                  rst_n,
   // cpu port
   input  logic                  req,
   input  logic                  ctrl_sel,
   input  cache_pkg::word_addr_t addr,
   input  cache_pkg::data_t      wdata,
   input  cache_pkg::strb_t      wstrb,
   output logic                  ack,
   output cache_pkg::data_t      rdata,
   // chain
   input  logic                  invalidate_in,
   output logic                  invalidate_out,
   input  logic                  wtb_empty_in,
   output logic                  wtb_empty_out,
   // next-level memory
   output logic                  mem_cmd_valid,
   output cache_pkg::mem_cmd_e   mem_cmd,
   output cache_pkg::word_addr_t mem_addr,
   output cache_pkg::data_t      mem_wdata,
   output cache_pkg::strb_t      mem_wstrb,
   input  logic                  credit_return,
   input  logic                  mem_rsp_valid,
   input  cache_pkg::data_t      mem_rsp_data
);

   logic                  data_req, data_ack, ctrl_req, ctrl_ack, ctrl_write;
   cache_pkg::word_addr_t addr_reg, write_addr;
   cache_pkg::data_t      wdata_reg, data_rdata, ctrl_rdata, write_wdata, fill_word;
   cache_pkg::strb_t      wstrb_reg, write_wstrb;
   logic                  write_valid, write_ready, fetch_valid, fetch_ready, fill_valid;
   cache_pkg::line_addr_t fetch_addr;
   logic [cache_pkg::line_off_w-1:0] fill_off;
   logic                  read_hit, read_miss, write_hit, write_miss, wtb_empty;

   assign ctrl_write = |wstrb_reg;

   cache_front_end front_end (
      .clk, .rst_n, .req, .ctrl_sel, .addr, .wdata, .wstrb, .ack, .rdata,
      .data_req, .ctrl_req, .addr_reg, .wdata_reg, .wstrb_reg,
      .data_ack, .data_rdata, .ctrl_ack, .ctrl_rdata
   );

   cache_memory memory (
      .clk, .rst_n, .data_req, .addr_reg, .wdata_reg, .wstrb_reg, .data_ack, .data_rdata,
      .write_valid, .write_addr, .write_wdata, .write_wstrb, .write_ready,
      .fetch_valid, .fetch_addr, .fetch_ready, .fill_valid, .fill_word, .fill_off,
      .invalidate_out, .read_hit, .read_miss, .write_hit, .write_miss
   );

   cache_back_end back_end (
      .clk, .rst_n, .write_valid, .write_addr, .write_wdata, .write_wstrb, .write_ready,
      .fetch_valid, .fetch_addr, .fetch_ready, .fill_valid, .fill_word, .fill_off,
      .wtb_empty_in, .wtb_empty, .wtb_empty_out,
      .mem_cmd_valid, .mem_cmd, .mem_addr, .mem_wdata, .mem_wstrb,
      .credit_return, .mem_rsp_valid, .mem_rsp_data
   );

   // register address is the low bits of the word address
   cache_control control (
      .clk, .rst_n, .ctrl_req,
      .ctrl_addr  (addr_reg[cache_pkg::ctrl_addr_w-1:0]),
      .ctrl_write, .ctrl_ack, .ctrl_rdata,
      .read_hit, .read_miss, .write_hit, .write_miss, .wtb_empty,
      .invalidate_in, .invalidate_out
   );

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cache_tb -o cache_sim \
   && ./obj_dir/cache_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
   && echo "run passed" \
   || { echo "run failed"; exit 1; }

//--- src.f
rtl/cache_pkg.sv
rtl/cache_front_end.sv
rtl/cache_memory.sv
rtl/cache_back_end.sv
rtl/cache_control.sv
rtl/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv

//--- tests/cache_tb.sv
/*
 Cache subsystem testbench
 Drives the CPU port against a shadow model of the direct-mapped
 write-through cache and checks data, counters, status and memory
 */

`timescale 1ns/1ps

module cache_tb;

   localparam int nwords = 2 ** cache_pkg::addr_w;
   localparam int nlines = 2 ** cache_pkg::index_w;

   logic                  clk;
   logic                  rst_n;
   logic                  req;
   logic                  ctrl_sel;
   logic                  ack;
   cache_pkg::word_addr_t addr;
   cache_pkg::data_t      wdata;
   cache_pkg::data_t      rdata;
   cache_pkg::strb_t      wstrb;
   logic                  invalidate_in;
   logic                  invalidate_out;
   logic                  wtb_empty_in;
   logic                  wtb_empty_out;
   logic                  mem_cmd_valid;
   cache_pkg::mem_cmd_e   mem_cmd;
   cache_pkg::word_addr_t mem_addr;
   cache_pkg::data_t      mem_wdata;
   cache_pkg::strb_t      mem_wstrb;
   logic                  credit_return;
   logic                  mem_rsp_valid;
   cache_pkg::data_t      mem_rsp_data;
   logic                  hold_credits;
   logic                  rsp_gap;

   // shadow of memory, tags and counters
   cache_pkg::data_t      shadow_mem [nwords];
   cache_pkg::tag_t       ref_tag [nlines];
   logic [nlines-1:0]     ref_valid;
   cache_pkg::cnt_t       ref_rd_hits;
   cache_pkg::cnt_t       ref_rd_misses;
   cache_pkg::cnt_t       ref_wr_hits;
   cache_pkg::cnt_t       ref_wr_misses;

   cache_pkg::data_t      exp_data [$];
   logic                  exp_chk [$];
   logic [15:0]           lfsr_q;
   int                    issued;
   int                    cycles;
   int                    writes_issued;
   int                    writes_taken;

   cache_top dut (.*);

   mem_model next_mem (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input cache_pkg::data_t got,
                              input cache_pkg::data_t exp);
      if (got !== exp) abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   function automatic cache_pkg::data_t fill_pattern(int i);
      logic [11:0] a;
      a = 12'(i);
      return {a, 4'hc, ~a, 4'h3};
   endfunction

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic take_bit();
      logic fb;
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] take_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) r = {r[30:0], take_bit()};
      return r;
   endfunction

   // direct-mapped, write no-allocate, write hit keeps the line
   function automatic cache_pkg::data_t ref_access(cache_pkg::word_addr_t a,
                                                   cache_pkg::data_t wd, cache_pkg::strb_t ws);
      cache_pkg::index_t idx;
      cache_pkg::tag_t   tag;
      logic              hit;
      idx = a[cache_pkg::line_off_w +: cache_pkg::index_w];
      tag = a[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
      hit = ref_valid[idx] && (ref_tag[idx] == tag);
      if (ws != '0) begin
         if (hit) begin
            ref_wr_hits++;
         end else begin
            ref_wr_misses++;
         end
         for (int b = 0; b < cache_pkg::nbytes; b++) begin
            if (ws[b]) shadow_mem[a][8*b +: 8] = wd[8*b +: 8];
         end
         return '0;
      end
      if (hit) begin
         ref_rd_hits++;
      end else begin
         ref_rd_misses++;
         ref_valid[idx] = 1'b1;
         ref_tag[idx]   = tag;
      end
      return shadow_mem[a];
   endfunction

   // called on a falling edge, returns one cycle after ack
   task automatic cpu_access(input logic sel, input cache_pkg::word_addr_t a,
                             input cache_pkg::data_t wd, input cache_pkg::strb_t ws,
                             input logic chk, input cache_pkg::data_t expv);
      exp_data.push_back(expv);
      exp_chk.push_back(chk);
      issued++;
      req      = 1'b1;
      ctrl_sel = sel;
      addr     = a;
      wdata    = wd;
      wstrb    = ws;
      do begin
         @(negedge clk);
         rsp_gap = take_bit();
      end while (!ack);
      req      = 1'b0;
      ctrl_sel = 1'b0;
      wstrb    = '0;
      @(negedge clk);
   endtask

   task automatic data_write(input cache_pkg::word_addr_t a, input cache_pkg::data_t wd,
                             input cache_pkg::strb_t ws);
      cache_pkg::data_t e;
      e = ref_access(a, wd, ws);
      writes_issued++;
      cpu_access(1'b0, a, wd, ws, 1'b0, e);
   endtask

   task automatic data_read(input cache_pkg::word_addr_t a);
      cache_pkg::data_t e;
      e = ref_access(a, '0, '0);
      cpu_access(1'b0, a, '0, '0, 1'b1, e);
   endtask

   task automatic reg_read(input cache_pkg::ctrl_reg_e r, input cache_pkg::data_t e);
      cpu_access(1'b1, cache_pkg::word_addr_t'(r), '0, '0, 1'b1, e);
   endtask

   task automatic reg_write(input cache_pkg::ctrl_reg_e r);
      cpu_access(1'b1, cache_pkg::word_addr_t'(r), '0, 4'hf, 1'b0, '0);
   endtask

   task automatic check_counters();
      reg_read(cache_pkg::read_hits, ref_rd_hits);
      reg_read(cache_pkg::read_misses, ref_rd_misses);
      reg_read(cache_pkg::write_hits, ref_wr_hits);
      reg_read(cache_pkg::write_misses, ref_wr_misses);
   endtask

   task automatic random_write(input cache_pkg::word_addr_t a);
      cache_pkg::strb_t ws;
      ws = cache_pkg::strb_t'(take_bits(4));
      if (ws == '0) ws = 4'h1;
      data_write(a, take_bits(32), ws);
   endtask

   // rdata is compared on every ack
   always @(posedge clk) begin : compare
      logic             chk;
      cache_pkg::data_t e;
      if (ack) begin
         if (exp_data.size() == 0) begin
            abort_run("an ack arrived with no request outstanding");
         end else begin
            chk = exp_chk.pop_front();
            e   = exp_data.pop_front();
            if (chk) check_value("rdata", rdata, e);
         end
      end
   end

   // write commands taken by the next-level memory
   always @(posedge clk) begin
      if (mem_cmd_valid && (mem_cmd == cache_pkg::write_word)) writes_taken++;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > 200 * issued + 1000) abort_run("the run did not finish within its cycle limit");
   end

   initial begin
      cache_pkg::word_addr_t base;
      cache_pkg::word_addr_t a;
      rst_n         = 1'b0;
      req           = 1'b0;
      ctrl_sel      = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      wtb_empty_in  = 1'b1;
      hold_credits  = 1'b0;
      rsp_gap       = 1'b0;
      lfsr_q        = 16'd16;
      issued        = 0;
      cycles        = 0;
      writes_issued = 0;
      writes_taken  = 0;
      ref_valid     = '0;
      ref_rd_hits   = '0;
      ref_rd_misses = '0;
      ref_wr_hits   = '0;
      ref_wr_misses = '0;
      for (int i = 0; i < nwords; i++) shadow_mem[cache_pkg::word_addr_t'(i)] = fill_pattern(i);
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // write miss, then read refills with merged bytes
      for (int n = 0; n < 4; n++) begin
         a = cache_pkg::word_addr_t'(take_bits(12));
         random_write(a);
         data_read(a);
      end

      // one line read three times over
      base = cache_pkg::word_addr_t'(take_bits(10) << 2);
      for (int p = 0; p < 3; p++) begin
         for (int w = 0; w < 4; w++) data_read(base | cache_pkg::word_addr_t'(w));
      end
      check_counters();

      // write hits, plus a write miss to the same index that must not allocate
      for (int n = 0; n < 6; n++) begin
         a = base | cache_pkg::word_addr_t'(take_bits(2));
         random_write(a);
         data_read(a);
      end
      random_write(base ^ 12'h800);
      data_read(base);
      check_counters();

      // invalidate by register, then by the chain input
      reg_write(cache_pkg::invalidate);
      ref_valid = '0;
      for (int w = 0; w < 4; w++) data_read(base | cache_pkg::word_addr_t'(w));
      check_counters();
      invalidate_in = 1'b1;
      @(posedge clk);
      check_value("invalidate_out", cache_pkg::data_t'(invalidate_out), 32'd1);
      @(negedge clk);
      invalidate_in = 1'b0;
      ref_valid     = '0;
      @(negedge clk);
      for (int w = 0; w < 4; w++) data_read(base | cache_pkg::word_addr_t'(w));
      check_counters();

      // write burst while the memory holds its credits back
      while (!wtb_empty_out) @(negedge clk);
      hold_credits = 1'b1;
      fork
         begin
            repeat (80) @(negedge clk);
            hold_credits = 1'b0;
         end
         begin
            for (int n = 0; n < 6; n++) random_write(base | cache_pkg::word_addr_t'(take_bits(2)));
            reg_read(cache_pkg::status, 32'd0);
            check_value("wtb_empty_out", cache_pkg::data_t'(wtb_empty_out), 32'd0);
            for (int n = 0; n < 3; n++) random_write(base | cache_pkg::word_addr_t'(take_bits(2)));
         end
      join
      while (writes_taken != writes_issued) @(negedge clk);
      reg_read(cache_pkg::status, 32'd1);
      check_value("wtb_empty_out", cache_pkg::data_t'(wtb_empty_out), 32'd1);
      wtb_empty_in = 1'b0;
      @(posedge clk);
      check_value("wtb_empty_out", cache_pkg::data_t'(wtb_empty_out), 32'd0);
      @(negedge clk);
      wtb_empty_in = 1'b1;
      @(negedge clk);
      for (int w = 0; w < 4; w++) data_read(base | cache_pkg::word_addr_t'(w));

      // counters cleared
      reg_write(cache_pkg::clear_counters);
      ref_rd_hits   = '0;
      ref_rd_misses = '0;
      ref_wr_hits   = '0;
      ref_wr_misses = '0;
      check_counters();

      while (!wtb_empty_out) @(negedge clk);
      for (int i = 0; i < nwords; i++) begin
         check_value($sformatf("mem[%h]", cache_pkg::word_addr_t'(i)),
                     next_mem.words[cache_pkg::word_addr_t'(i)],
                     shadow_mem[cache_pkg::word_addr_t'(i)]);
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- tests/mem_model.sv
/*
 Next-level memory model
 Word memory behind the credit command channel, returns each credit two
 cycles after its command and answers line reads with four response beats
 */

`timescale 1ns/1ps

module mem_model (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  mem_cmd_valid,
   input  cache_pkg::mem_cmd_e   mem_cmd,
   input  cache_pkg::word_addr_t mem_addr,
   input  cache_pkg::data_t      mem_wdata,
   input  cache_pkg::strb_t      mem_wstrb,
   output logic                  credit_return,
   output logic                  mem_rsp_valid,
   output cache_pkg::data_t      mem_rsp_data,
   // stimulus knobs from the testbench
   input  logic                  hold_credits,
   input  logic                  rsp_gap
);

   cache_pkg::data_t words [2 ** cache_pkg::addr_w];
   cache_pkg::data_t rsp_q [$];
   logic             due_q;
   logic [1:0]       owed_q;

   // every word carries its own address
   initial begin
      logic [11:0] a;
      for (int i = 0; i < 2 ** cache_pkg::addr_w; i++) begin
         a = 12'(i);
         words[cache_pkg::word_addr_t'(i)] = {a, 4'hc, ~a, 4'h3};
      end
   end

   // credits owed pile up while held back
   assign credit_return = !hold_credits && (owed_q != 2'd0);

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         due_q  <= 1'b0;
         owed_q <= 2'd0;
      end else begin
         due_q  <= mem_cmd_valid;
         owed_q <= owed_q + 2'(due_q) - 2'(credit_return);
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_rsp_valid <= 1'b0;
         mem_rsp_data  <= '0;
         rsp_q.delete();
      end else begin
         // optional idle cycle after each beat
         if ((rsp_q.size() != 0) && !(mem_rsp_valid && rsp_gap)) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp_data  <= rsp_q.pop_front();
         end else begin
            mem_rsp_valid <= 1'b0;
         end
         if (mem_cmd_valid) begin
            if (mem_cmd == cache_pkg::write_word) begin
               for (int b = 0; b < cache_pkg::nbytes; b++) begin
                  if (mem_wstrb[b]) words[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
               end
            end else begin
               for (int w = 0; w < 4; w++) begin
                  rsp_q.push_back(words[{mem_addr[cache_pkg::addr_w-1:2], 2'(w)}]);
               end
            end
         end
      end
   end

endmodule
